//--- design/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// word capacity of the instruction queue
// any even depth of 4 or more works, pairs are always written together
`define QUEUE_DEPTH 4

// r0 reads as zero, never a dependency
`define ZERO_REG 5'd0

`endif

//--- design/issue_pkg.sv
`default_nettype none

package issue_pkg;

	typedef logic [4:0] RegNum_t;

	// register-register format
	typedef struct packed {
		logic [5:0] opcode;
		RegNum_t    rs;
		RegNum_t    rt;
		RegNum_t    rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} RType_t;

	// immediate format
	typedef struct packed {
		logic [5:0]  opcode;
		RegNum_t     rs;
		RegNum_t     rt;
		logic [15:0] imm;
	} IType_t;

	typedef union packed {
		RType_t r;
		IType_t i;
	} InstWord_t;

	typedef struct packed {
		InstWord_t word0;
		InstWord_t word1;
	} FetchPair_t;

	typedef enum logic [2:0] {
		ALU_REG,
		ALU_IMM,
		LOAD,
		STORE,
		BRANCH,
		ILLEGAL
	} OpClass_t;

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI,
		ALU_EQ,
		ALU_NE
	} AluOp_t;

	typedef struct packed {
		logic        valid;
		OpClass_t    op_class;
		AluOp_t      alu_op;
		RegNum_t     src1;
		logic        reads_src1;
		RegNum_t     src2;
		logic        reads_src2;
		RegNum_t     dst;
		logic        writes_reg;
		logic [31:0] imm;
	} DecodedInst_t;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// funct field under SPECIAL
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

`default_nettype wire

//--- design/inst_queue.sv
`default_nettype none
`timescale 1ns/100ps

`include "issue_config.svh"

module inst_queue
	import issue_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       fetch_valid,
	input  FetchPair_t fetch_pair,
	output logic       fetch_ready,
	input  logic [1:0] pop_count,
	output logic [1:0] head_valid,
	output FetchPair_t head_words
);

	localparam int DEPTH = `QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	InstWord_t mem [DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr_1;
	logic [PTR_W-1:0] wr_ptr_1;
	logic [CNT_W-1:0] count;
	logic             push;

	// pointer advance with wrap
	// depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_add(
		input logic [PTR_W-1:0] ptr,
		input logic [1:0]       n
	);
		logic [PTR_W:0] sum;
		sum = {1'b0, ptr} + (PTR_W+1)'(n);
		if (sum >= (PTR_W+1)'(DEPTH))
		begin
			sum = sum - (PTR_W+1)'(DEPTH);
		end
		return sum[PTR_W-1:0];
	endfunction

	// room for a whole pair
	assign fetch_ready = (count <= CNT_W'(DEPTH - 2));
	assign push        = fetch_valid & fetch_ready;

	assign rd_ptr_1 = ptr_add(rd_ptr, 2'd1);
	assign wr_ptr_1 = ptr_add(wr_ptr, 2'd1);

	// bit 0 is the oldest word
	assign head_valid[0] = (count != '0);
	assign head_valid[1] = (count >= CNT_W'(2));

	assign head_words.word0 = mem[rd_ptr];
	assign head_words.word1 = mem[rd_ptr_1];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[wr_ptr]   <= fetch_pair.word0;
			mem[wr_ptr_1] <= fetch_pair.word1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= ptr_add(wr_ptr, 2'd2);
			end
			rd_ptr <= ptr_add(rd_ptr, pop_count);
			count  <= count + CNT_W'({push, 1'b0}) - CNT_W'(pop_count);
		end
	end

	// issue side must only pop what is present
	assert property (@(posedge clk) disable iff (rst) pop_count <= count)
		else $error("inst_queue: pop of %0d with only %0d words", pop_count, count);

	// a pair write never lands on an unread word
	assert property (@(posedge clk) disable iff (rst)
		push |-> (count == '0) || ((wr_ptr != rd_ptr) && (wr_ptr_1 != rd_ptr)))
		else $error("inst_queue: pair write at %0d over unread word at %0d", wr_ptr, rd_ptr);

endmodule

`default_nettype wire

//--- design/inst_decode.sv
`default_nettype none
`timescale 1ns/100ps

module inst_decode
	import issue_pkg::*;
(
	input  InstWord_t    word,
	input  logic         present,
	output DecodedInst_t decoded
);

	logic [31:0] imm_sext;
	logic [31:0] imm_zext;
	logic [31:0] imm_upper;

	assign imm_sext  = {{16{word.i.imm[15]}}, word.i.imm};
	assign imm_zext  = {16'h0000, word.i.imm};
	assign imm_upper = {word.i.imm, 16'h0000};

	always_comb
	begin
		// unknown words fall through as illegal, no register usage
		decoded          = '0;
		decoded.valid    = present;
		decoded.op_class = ILLEGAL;
		decoded.alu_op   = ALU_NOP;

		case (word.r.opcode)
			OP_SPECIAL:
			begin
				case (word.r.funct)
					FN_ADDU: decoded.alu_op = ALU_ADD;
					FN_SUBU: decoded.alu_op = ALU_SUB;
					FN_AND:  decoded.alu_op = ALU_AND;
					FN_OR:   decoded.alu_op = ALU_OR;
					FN_XOR:  decoded.alu_op = ALU_XOR;
					FN_SLT:  decoded.alu_op = ALU_SLT;
					default: decoded.alu_op = ALU_NOP;
				endcase
				if (decoded.alu_op != ALU_NOP)
				begin
					decoded.op_class   = ALU_REG;
					decoded.src1       = word.r.rs;
					decoded.reads_src1 = 1'b1;
					decoded.src2       = word.r.rt;
					decoded.reads_src2 = 1'b1;
					decoded.dst        = word.r.rd;
					decoded.writes_reg = 1'b1;
				end
			end
			OP_ADDIU, OP_ANDI, OP_ORI:
			begin
				decoded.op_class   = ALU_IMM;
				decoded.src1       = word.i.rs;
				decoded.reads_src1 = 1'b1;
				decoded.dst        = word.i.rt;
				decoded.writes_reg = 1'b1;
				if (word.i.opcode == OP_ADDIU)
				begin
					decoded.alu_op = ALU_ADD;
					decoded.imm    = imm_sext;
				end
				else if (word.i.opcode == OP_ANDI)
				begin
					decoded.alu_op = ALU_AND;
					decoded.imm    = imm_zext;
				end
				else
				begin
					decoded.alu_op = ALU_OR;
					decoded.imm    = imm_zext;
				end
			end
			OP_LUI:
			begin
				// rs field unused
				decoded.op_class   = ALU_IMM;
				decoded.alu_op     = ALU_LUI;
				decoded.dst        = word.i.rt;
				decoded.writes_reg = 1'b1;
				decoded.imm        = imm_upper;
			end
			OP_LW:
			begin
				decoded.op_class   = LOAD;
				decoded.alu_op     = ALU_ADD;
				decoded.src1       = word.i.rs;
				decoded.reads_src1 = 1'b1;
				decoded.dst        = word.i.rt;
				decoded.writes_reg = 1'b1;
				decoded.imm        = imm_sext;
			end
			OP_SW:
			begin
				// rt is the store data
				decoded.op_class   = STORE;
				decoded.alu_op     = ALU_ADD;
				decoded.src1       = word.i.rs;
				decoded.reads_src1 = 1'b1;
				decoded.src2       = word.i.rt;
				decoded.reads_src2 = 1'b1;
				decoded.imm        = imm_sext;
			end
			OP_BEQ, OP_BNE:
			begin
				decoded.op_class   = BRANCH;
				decoded.alu_op     = (word.i.opcode == OP_BEQ) ? ALU_EQ : ALU_NE;
				decoded.src1       = word.i.rs;
				decoded.reads_src1 = 1'b1;
				decoded.src2       = word.i.rt;
				decoded.reads_src2 = 1'b1;
				decoded.imm        = imm_sext;
			end
			default:
			begin
				decoded.op_class = ILLEGAL;
			end
		endcase
	end

	always_comb
	begin
		if (decoded.op_class == ILLEGAL)
		begin
			assert final (!decoded.writes_reg)
				else $error("inst_decode: illegal word %h writes a register", word);
		end
	end

endmodule

`default_nettype wire

//--- design/pair_check.sv
`default_nettype none
`timescale 1ns/100ps

`include "issue_config.svh"

module pair_check
	import issue_pkg::*;
(
	input  DecodedInst_t first,
	input  DecodedInst_t second,
	output logic         take_second
);

	logic both_present;
	logic any_illegal;
	logic any_branch;
	logic first_mem;
	logic second_mem;
	logic both_mem;
	logic first_dst_live;
	logic raw_src1;
	logic raw_src2;
	logic raw_hazard;

	assign both_present = first.valid & second.valid;

	assign any_illegal = (first.op_class == ILLEGAL) | (second.op_class == ILLEGAL);

	// branch and delay slot stay in pipe a
	assign any_branch = (first.op_class == BRANCH) | (second.op_class == BRANCH);

	// single memory port
	assign first_mem  = (first.op_class == LOAD) | (first.op_class == STORE);
	assign second_mem = (second.op_class == LOAD) | (second.op_class == STORE);
	assign both_mem   = first_mem & second_mem;

	// r0 writes never create a dependency
	assign first_dst_live = first.writes_reg & (first.dst != `ZERO_REG);

	assign raw_src1   = second.reads_src1 & (second.src1 == first.dst);
	assign raw_src2   = second.reads_src2 & (second.src2 == first.dst);
	assign raw_hazard = first_dst_live & (raw_src1 | raw_src2);

	assign take_second = both_present
		& ~any_illegal
		& ~any_branch
		& ~both_mem
		& ~raw_hazard;

endmodule

`default_nettype wire

//--- design/dual_issue.sv
`default_nettype none
`timescale 1ns/100ps

module dual_issue
	import issue_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         fetch_valid,
	input  FetchPair_t   fetch_pair,
	output logic         fetch_ready,
	input  logic         issue_stall,
	output logic         issue_valid,
	output DecodedInst_t issue_a,
	output DecodedInst_t issue_b
);

	logic [1:0]   head_valid;
	FetchPair_t   head_words;
	DecodedInst_t dec_a;
	DecodedInst_t dec_b;
	logic         take_second;
	logic [1:0]   pop_count;

	inst_queue queue_instance(
		.clk,
		.rst,
		.fetch_valid,
		.fetch_pair,
		.fetch_ready,
		.pop_count,
		.head_valid,
		.head_words
	);

	inst_decode decode_a(
		.word(head_words.word0),
		.present(head_valid[0]),
		.decoded(dec_a)
	);

	inst_decode decode_b(
		.word(head_words.word1),
		.present(head_valid[1]),
		.decoded(dec_b)
	);

	pair_check pair_instance(
		.first(dec_a),
		.second(dec_b),
		.take_second
	);

	// pop happens on the same edge the output registers load
	always_comb
	begin
		if (issue_stall || !head_valid[0])
			pop_count = 2'd0;
		else if (take_second)
			pop_count = 2'd2;
		else
			pop_count = 2'd1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			issue_valid   <= 1'b0;
			issue_a.valid <= 1'b0;
			issue_b.valid <= 1'b0;
		end
		else if (!issue_stall)
		begin
			issue_valid   <= head_valid[0];
			issue_a       <= dec_a;
			issue_b       <= dec_b;
			// unpaired word waits at the head for pipe a
			issue_b.valid <= take_second;
		end
	end

	assert property (@(posedge clk) disable iff (rst) issue_b.valid |-> issue_valid)
		else $error("dual_issue: pipe b issued without pipe a");

endmodule

`default_nettype wire

//--- testbench/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// reference decode taken straight from the MIPS encodings
function automatic DecodedInst_t model_decode(input InstWord_t word, input logic present);
	DecodedInst_t d;
	logic [31:0]  w;
	logic [31:0]  sx;
	w          = word;
	sx         = {{16{w[15]}}, w[15:0]};
	d          = '0;
	d.valid    = present;
	d.op_class = ILLEGAL;
	d.alu_op   = ALU_NOP;
	case (w[31:26])
		6'h00:
		begin
			case (w[5:0])
				6'h21: d.alu_op = ALU_ADD;
				6'h23: d.alu_op = ALU_SUB;
				6'h24: d.alu_op = ALU_AND;
				6'h25: d.alu_op = ALU_OR;
				6'h26: d.alu_op = ALU_XOR;
				6'h2a: d.alu_op = ALU_SLT;
				default: d.alu_op = ALU_NOP;
			endcase
			if (d.alu_op != ALU_NOP)
				d.op_class = ALU_REG;
		end
		6'h09:
		begin
			d.op_class = ALU_IMM;
			d.alu_op   = ALU_ADD;
			d.imm      = sx;
		end
		6'h0c, 6'h0d:
		begin
			d.op_class = ALU_IMM;
			d.alu_op   = w[26] ? ALU_OR : ALU_AND;
			d.imm      = {16'h0000, w[15:0]};
		end
		6'h0f:
		begin
			d.op_class = ALU_IMM;
			d.alu_op   = ALU_LUI;
			d.imm      = {w[15:0], 16'h0000};
		end
		6'h23, 6'h2b:
		begin
			// opcode bit 3 separates SW from LW
			d.op_class = w[29] ? STORE : LOAD;
			d.alu_op   = ALU_ADD;
			d.imm      = sx;
		end
		6'h04, 6'h05:
		begin
			d.op_class = BRANCH;
			d.alu_op   = w[26] ? ALU_NE : ALU_EQ;
			d.imm      = sx;
		end
		default:
			d.op_class = ILLEGAL;
	endcase
	// operand usage follows the class
	case (d.op_class)
		ALU_REG:
		begin
			d.src1       = w[25:21];
			d.reads_src1 = 1'b1;
			d.src2       = w[20:16];
			d.reads_src2 = 1'b1;
			d.dst        = w[15:11];
			d.writes_reg = 1'b1;
		end
		ALU_IMM, LOAD:
		begin
			d.dst        = w[20:16];
			d.writes_reg = 1'b1;
			if (d.alu_op != ALU_LUI)
			begin
				d.src1       = w[25:21];
				d.reads_src1 = 1'b1;
			end
		end
		STORE, BRANCH:
		begin
			d.src1       = w[25:21];
			d.reads_src1 = 1'b1;
			d.src2       = w[20:16];
			d.reads_src2 = 1'b1;
		end
		default:
			d.writes_reg = 1'b0;
	endcase
	return d;
endfunction

// can the younger word join the older one in the same cycle
function automatic logic model_pairs(input DecodedInst_t a, input DecodedInst_t b);
	logic a_mem;
	logic b_mem;
	logic dep;
	a_mem = (a.op_class == LOAD) || (a.op_class == STORE);
	b_mem = (b.op_class == LOAD) || (b.op_class == STORE);
	dep   = a.writes_reg && (a.dst != 5'd0)
		&& ((b.reads_src1 && b.src1 == a.dst) || (b.reads_src2 && b.src2 == a.dst));
	if (!a.valid || !b.valid)
		return 1'b0;
	if (a.op_class == ILLEGAL || b.op_class == ILLEGAL)
		return 1'b0;
	if (a.op_class == BRANCH || b.op_class == BRANCH)
		return 1'b0;
	return !(a_mem && b_mem) && !dep;
endfunction

`endif

//--- testbench/dual_issue_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "issue_config.svh"

module dual_issue_tb
	import issue_pkg::*;
();

	localparam int NUM_TESTS   = 300;
	localparam int CLK_NS      = 20;
	localparam int WATCHDOG_NS = (NUM_TESTS + 1) * 40 * CLK_NS;

	logic         clk = 1'b0;
	logic         rst;
	logic         fetch_valid;
	FetchPair_t   fetch_pair;
	logic         fetch_ready;
	logic         issue_stall;
	logic         issue_valid;
	DecodedInst_t issue_a;
	DecodedInst_t issue_b;

	integer seed;
	logic   driving        = 1'b0;
	int     error_count    = 0;
	int     test_count     = 0;
	int     failed_tests   = 0;
	int     paired_count   = 0;
	int     zero_dep_pairs = 0;

	// accepted words in order and the edge that accepted each
	InstWord_t word_q[$];
	int        accept_q[$];

	`include "issue_model.svh"

	dual_issue uut(
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_pair(fetch_pair),
		.fetch_ready(fetch_ready),
		.issue_stall(issue_stall),
		.issue_valid(issue_valid),
		.issue_a(issue_a),
		.issue_b(issue_b)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// registers 0..3 only, so dependencies show up often
	function automatic InstWord_t random_word();
		logic [31:0] w;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		int          kind;
		kind = $unsigned($random(seed)) % 16;
		rs   = 5'($unsigned($random(seed)) % 4);
		rt   = 5'($unsigned($random(seed)) % 4);
		rd   = 5'($unsigned($random(seed)) % 4);
		imm  = 16'($random(seed));
		case (kind)
			0: w = {6'h00, rs, rt, rd, 5'd0, 6'h21};
			1: w = {6'h00, rs, rt, rd, 5'd0, 6'h23};
			2: w = {6'h00, rs, rt, rd, 5'd0, 6'h24};
			3: w = {6'h00, rs, rt, rd, 5'd0, 6'h25};
			4: w = {6'h00, rs, rt, rd, 5'd0, 6'h26};
			5: w = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
			6: w = {6'h09, rs, rt, imm};
			7: w = {6'h0c, rs, rt, imm};
			8: w = {6'h0d, rs, rt, imm};
			9: w = {6'h0f, rs, rt, imm};
			10: w = {6'h23, rs, rt, imm};
			11: w = {6'h2b, rs, rt, imm};
			12: w = {6'h04, rs, rt, imm};
			13: w = {6'h05, rs, rt, imm};
			// ADDI and SLL are outside the supported set
			14: w = {6'h08, rs, rt, imm};
			default: w = {6'h00, rs, rt, rd, 5'd3, 6'h00};
		endcase
		return w;
	endfunction

	always @(posedge clk)
	begin
		if (driving)
		begin
			fetch_valid      <= ($unsigned($random(seed)) % 8) < 5;
			fetch_pair.word0 <= random_word();
			fetch_pair.word1 <= random_word();
			issue_stall      <= ($unsigned($random(seed)) % 4) == 0;
		end
	end

	task automatic check_record(input string name, input DecodedInst_t expected,
		input DecodedInst_t actual);
		if (actual !== expected)
		begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_pairing(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAIL %s expected %b actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAIL %s expected %b actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	initial
	begin
		int           edge_n;
		int           errors_before;
		logic         loaded;
		logic         see0;
		logic         see1;
		logic         exp_take;
		logic         exp_ready;
		logic         snap_valid;
		DecodedInst_t exp_a;
		DecodedInst_t exp_b;
		DecodedInst_t snap_a;
		DecodedInst_t snap_b;

		seed        = 32'h98c5_dd32;
		rst         = 1'b1;
		fetch_valid = 1'b0;
		fetch_pair  = '0;
		issue_stall = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("reset fetch_ready", 1'b1, fetch_ready);
		check_flag("reset issue_valid", 1'b0, issue_valid);
		check_flag("reset issue_a.valid", 1'b0, issue_a.valid);
		check_flag("reset issue_b.valid", 1'b0, issue_b.valid);
		$display("reset: %s", (error_count == 0) ? "ok" : "mismatch");

		driving    = 1'b1;
		edge_n     = 0;
		snap_valid = issue_valid;
		snap_a     = issue_a;
		snap_b     = issue_b;
		while (test_count < NUM_TESTS)
		begin
			// free space in the model queue decides fetch_ready
			exp_ready = (word_q.size() <= `QUEUE_DEPTH - 2);
			check_flag($sformatf("edge_%0d fetch_ready", edge_n), exp_ready, fetch_ready);

			// what the coming edge will see
			loaded = !issue_stall;
			if (fetch_valid && fetch_ready)
			begin
				word_q.push_back(fetch_pair.word0);
				word_q.push_back(fetch_pair.word1);
				accept_q.push_back(edge_n + 1);
				accept_q.push_back(edge_n + 1);
			end
			edge_n++;
			@(negedge clk);

			if (!loaded)
			begin
				check_flag($sformatf("stall_%0d issue_valid", edge_n), snap_valid,
					issue_valid);
				check_record($sformatf("stall_%0d pipe a", edge_n), snap_a, issue_a);
				check_record($sformatf("stall_%0d pipe b", edge_n), snap_b, issue_b);
			end
			else
			begin
				// a word reaches the head one edge after it is accepted
				see0 = (accept_q.size() > 0) && (accept_q[0] < edge_n);
				see1 = (accept_q.size() > 1) && (accept_q[1] < edge_n);
				check_flag($sformatf("edge_%0d issue_valid", edge_n), see0, issue_valid);
				if (issue_valid === 1'b1 && see0)
				begin
					test_count++;
					errors_before = error_count;
					exp_a    = model_decode(word_q[0], 1'b1);
					exp_b    = see1 ? model_decode(word_q[1], 1'b1) : '0;
					exp_take = see1 && model_pairs(exp_a, exp_b);
					check_record($sformatf("issue_%0d pipe a", test_count), exp_a, issue_a);
					check_pairing($sformatf("issue_%0d pairing", test_count), exp_take,
						issue_b.valid);
					void'(word_q.pop_front());
					void'(accept_q.pop_front());
					if (exp_take)
					begin
						check_record($sformatf("issue_%0d pipe b", test_count), exp_b, issue_b);
						void'(word_q.pop_front());
						void'(accept_q.pop_front());
						paired_count++;
						if (exp_a.writes_reg && exp_a.dst == 5'd0
							&& ((exp_b.reads_src1 && exp_b.src1 == 5'd0)
							|| (exp_b.reads_src2 && exp_b.src2 == 5'd0)))
							zero_dep_pairs++;
					end
					if (error_count != errors_before)
						failed_tests++;
					$display("issue_%0d: %0d word(s) %s", test_count, exp_take ? 2 : 1,
						(error_count == errors_before) ? "ok" : "mismatch");
				end
			end
			snap_valid = issue_valid;
			snap_a     = issue_a;
			snap_b     = issue_b;
		end

		if (paired_count == 0 || zero_dep_pairs == 0)
		begin
			$display("ERROR: no pair through r0 or no pair at all was exercised");
			error_count++;
		end
		$display("tests %0d, failed %0d, errors %0d, pairs %0d, r0 pairs %0d",
			test_count, failed_tests, error_count, paired_count, zero_dep_pairs);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired after %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
+incdir+testbench
design/issue_pkg.sv
design/inst_queue.sv
design/inst_decode.sv
design/pair_check.sv
design/dual_issue.sv
testbench/dual_issue_tb.sv
